//--- rtl/histPkg.sv
`default_nettype none

package histPkg;

    // pixel index width, four pixels
    localparam int pixelBits = 2;

    // time bin index width, 32 bins per pixel
    localparam int binBits = 5;

    // histogram count width
    localparam int countBits = 8;

    // ram address is pixel index followed by bin index
    localparam int addrBits = pixelBits + binBits;

    // counts stick here instead of wrapping
    localparam logic [countBits-1:0] countMax = '1;

    // one photon event
    typedef struct packed {
        logic [pixelBits-1:0] pixel;
        logic [binBits-1:0]   bin;
    } histEvent;

    // one bin as read out during the sweep
    typedef struct packed {
        logic [pixelBits-1:0] pixel;
        logic [binBits-1:0]   bin;
        logic [countBits-1:0] count;
    } binReading;

    // peak of one pixel
    typedef struct packed {
        logic [pixelBits-1:0] pixel;
        logic [binBits-1:0]   bin;
        logic [countBits-1:0] count;
    } peakResult;

    // sequencer FSM states
    typedef enum logic [1:0] {IDLE, DRAIN, SWEEP, FLUSH} seqState;

endpackage

`default_nettype wire

//--- rtl/histRam.sv
`timescale 1ns/100ps
`default_nettype none

module histRam (
    input  logic                           clk,
    input  logic                           wrEn,
    input  logic [histPkg::addrBits-1:0]   wrAddr,
    input  logic [histPkg::countBits-1:0]  wrData,
    input  logic                           rdEn,
    input  logic [histPkg::addrBits-1:0]   rdAddr,
    output logic [histPkg::countBits-1:0]  rdData
);

    // one word per pixel and bin
    logic [histPkg::countBits-1:0] mem [0:(1 << histPkg::addrBits)-1];

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read port
    // same-address read and write in one cycle gives the old word
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

//--- rtl/histSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module histSequencer (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           eventValid,
    input  histPkg::histEvent              evt,
    input  logic                           frameEnd,
    output logic                           busy,
    output logic                           wrEn,
    output logic [histPkg::addrBits-1:0]   wrAddr,
    output logic [histPkg::countBits-1:0]  wrData,
    output logic                           rdEn,
    output logic [histPkg::addrBits-1:0]   rdAddr,
    input  logic [histPkg::countBits-1:0]  rdData,
    output logic                           binValid,
    output histPkg::binReading             binOut
);

    histPkg::seqState state;

    // shared timer for drain and flush
    logic [1:0] waitCnt;

    // sweep address, wraps back to zero after the last bin
    logic [histPkg::addrBits-1:0] sweepAddr;

    logic acceptEvent;
    logic acceptFrame;
    logic inSweep;

    // stage 1, read data returning
    logic                          s1Valid;
    logic                          s1Clear;
    logic [histPkg::addrBits-1:0]  s1Addr;

    // stage 2, write pending
    logic                          s2Valid;
    logic [histPkg::addrBits-1:0]  s2Addr;
    logic [histPkg::countBits-1:0] s2Data;

    // stage 3, value written last cycle, not yet visible on a read
    logic                          s3Valid;
    logic [histPkg::addrBits-1:0]  s3Addr;
    logic [histPkg::countBits-1:0] s3Data;

    logic [histPkg::countBits-1:0] baseCount;
    logic [histPkg::countBits-1:0] incCount;

    // inputs only count while idle, anything else is dropped
    assign acceptEvent = eventValid && (state == histPkg::IDLE);
    assign acceptFrame = frameEnd && (state == histPkg::IDLE);
    assign inSweep     = (state == histPkg::SWEEP);
    assign busy        = (state != histPkg::IDLE);

    // frame FSM
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= histPkg::IDLE;
            waitCnt   <= '0;
            sweepAddr <= '0;
        end else begin
            case (state)
                histPkg::IDLE: begin
                    if (acceptFrame) begin
                        state   <= histPkg::DRAIN;
                        waitCnt <= 2'd1;
                    end
                end
                histPkg::DRAIN: begin
                    // two cycles so the last event write lands
                    if (waitCnt == 2'd0) begin
                        state <= histPkg::SWEEP;
                    end else begin
                        waitCnt <= waitCnt - 2'd1;
                    end
                end
                histPkg::SWEEP: begin
                    sweepAddr <= sweepAddr + 1'b1;
                    if (sweepAddr == '1) begin
                        state   <= histPkg::FLUSH;
                        waitCnt <= 2'd2;
                    end
                end
                histPkg::FLUSH: begin
                    // last clear write and last peak still in flight
                    if (waitCnt == 2'd0) begin
                        state <= histPkg::IDLE;
                    end else begin
                        waitCnt <= waitCnt - 2'd1;
                    end
                end
                default: begin
                    state <= histPkg::IDLE;
                end
            endcase
        end
    end

    // read issue, sweep has the port to itself
    assign rdEn   = acceptEvent || inSweep;
    assign rdAddr = inSweep ? sweepAddr : {evt.pixel, evt.bin};

    // pipeline control
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            s1Clear <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            s1Valid <= rdEn;
            s1Clear <= inSweep;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    // pipeline payload
    always_ff @(posedge clk) begin
        s1Addr <= rdAddr;
        s2Addr <= s1Addr;
        // sweep reads are written back as zero
        s2Data <= s1Clear ? '0 : incCount;
        s3Addr <= s2Addr;
        s3Data <= s2Data;
    end

    // newest pending value wins over older one and over ram
    always_comb begin
        if (s2Valid && (s2Addr == s1Addr)) begin
            baseCount = s2Data;
        end else if (s3Valid && (s3Addr == s1Addr)) begin
            baseCount = s3Data;
        end else begin
            baseCount = rdData;
        end
    end

    // saturating increment
    assign incCount = (baseCount == histPkg::countMax) ? baseCount : baseCount + 1'b1;

    // write port
    assign wrEn   = s2Valid;
    assign wrAddr = s2Addr;
    assign wrData = s2Data;

    // swept bin goes downstream one cycle after its read
    assign binValid     = s1Valid && s1Clear;
    assign binOut.pixel = s1Addr[histPkg::addrBits-1 -: histPkg::pixelBits];
    assign binOut.bin   = s1Addr[histPkg::binBits-1:0];
    assign binOut.count = rdData;

endmodule

`default_nettype wire

//--- rtl/peakFinder.sv
`timescale 1ns/100ps
`default_nettype none

module peakFinder (
    input  logic               clk,
    input  logic               rstN,
    input  logic               binValid,
    input  histPkg::binReading binOut,
    output logic               peakValid,
    output histPkg::peakResult peak
);

    // best so far for the current pixel
    logic [histPkg::binBits-1:0]   bestBin;
    logic [histPkg::countBits-1:0] bestCount;

    logic                          firstBin;
    logic                          lastBin;
    logic                          takeNew;
    logic [histPkg::binBits-1:0]   candBin;
    logic [histPkg::countBits-1:0] candCount;

    // bins arrive in address order, bin 0 opens a pixel
    assign firstBin = (binOut.bin == '0);
    assign lastBin  = (binOut.bin == '1);

    // strictly greater only, so the lower bin keeps a tie
    // bin 0 always loads, which also gives 0/0 for an empty pixel
    assign takeNew = firstBin || (binOut.count > bestCount);

    assign candBin   = takeNew ? binOut.bin : bestBin;
    assign candCount = takeNew ? binOut.count : bestCount;

    // running maximum
    always_ff @(posedge clk) begin
        if (binValid) begin
            bestBin   <= candBin;
            bestCount <= candCount;
        end
    end

    // result includes the last bin itself
    always_ff @(posedge clk) begin
        if (binValid && lastBin) begin
            peak.pixel <= binOut.pixel;
            peak.bin   <= candBin;
            peak.count <= candCount;
        end
    end

    // one pulse per pixel
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            peakValid <= 1'b0;
        end else begin
            peakValid <= binValid && lastBin;
        end
    end

endmodule

`default_nettype wire

//--- rtl/histTop.sv
`timescale 1ns/100ps
`default_nettype none

module histTop (
    input  logic               clk,
    input  logic               rstN,
    input  logic               eventValid,
    input  histPkg::histEvent  evt,
    input  logic               frameEnd,
    output logic               busy,
    output logic               peakValid,
    output histPkg::peakResult peak
);

    // ram write port
    logic                          wrEn;
    logic [histPkg::addrBits-1:0]  wrAddr;
    logic [histPkg::countBits-1:0] wrData;

    // ram read port
    logic                          rdEn;
    logic [histPkg::addrBits-1:0]  rdAddr;
    logic [histPkg::countBits-1:0] rdData;

    // swept bins into the peak search
    logic                          binValid;
    histPkg::binReading            binOut;

    // event pipeline and frame FSM
    histSequencer uSeq (
        .clk        (clk),
        .rstN       (rstN),
        .eventValid (eventValid),
        .evt        (evt),
        .frameEnd   (frameEnd),
        .busy       (busy),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .rdEn       (rdEn),
        .rdAddr     (rdAddr),
        .rdData     (rdData),
        .binValid   (binValid),
        .binOut     (binOut)
    );

    // histogram storage, all pixels in one block
    histRam uRam (
        .clk    (clk),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

    // per-pixel peak
    peakFinder uPeak (
        .clk       (clk),
        .rstN      (rstN),
        .binValid  (binValid),
        .binOut    (binOut),
        .peakValid (peakValid),
        .peak      (peak)
    );

endmodule

`default_nettype wire

//--- test/histTb.sv
`timescale 1ns/100ps
`default_nettype none

module histTb;

    localparam int resetCycles    = 10;
    localparam int numPixels      = 1 << histPkg::pixelBits;
    localparam int numBins        = 1 << histPkg::binBits;
    localparam int countLimit     = (1 << histPkg::countBits) - 1;
    localparam int maxGap         = 3;
    localparam int sparseEvents   = 300;
    localparam int burstCount     = 60;
    localparam int maxBurst       = 6;
    localparam int saturationHits = 400;
    localparam int heavyPerPixel  = 100;
    localparam int lightEvents    = 40;
    localparam int frameCount     = 6;

    // worst case cycles spent sending events, gaps included
    localparam int eventCycles = sparseEvents * (maxGap + 1) + burstCount * (maxBurst + 2)
        + saturationHits + numPixels * heavyPerPixel + lightEvents * (maxGap + 1);
    localparam int watchdogCycles = resetCycles + eventCycles + 200 * frameCount;

    logic               clk;
    logic               rstN;
    logic               eventValid;
    histPkg::histEvent  evt;
    logic               frameEnd;
    logic               busy;
    logic               peakValid;
    histPkg::peakResult peak;

    // reference histogram, one count per pixel and bin
    int unsigned        modelCount [0:numPixels*numBins-1];
    histPkg::peakResult expectQ [$];
    histPkg::peakResult expHead;
    logic [31:0]        rngState;
    string              testName;

    histTop u_dut (
        .clk        (clk),
        .rstN       (rstN),
        .eventValid (eventValid),
        .evt        (evt),
        .frameEnd   (frameEnd),
        .busy       (busy),
        .peakValid  (peakValid),
        .peak       (peak)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned randomBelow(input int unsigned n);
        rngState = xorshift32(rngState);
        return rngState % n;
    endfunction

    task automatic clearModel();
        for (int i = 0; i < numPixels * numBins; i++) begin
            modelCount[i] = 0;
        end
    endtask

    // one event strobe, stays high until the next negedge drive
    task automatic sendEvent(input int unsigned pixel, input int unsigned bin);
        int unsigned addr;
        addr = pixel * numBins + bin;
        @(negedge clk);
        assert (!busy) else failRun($sformatf("event in test %s sent while the core is busy",
            testName));
        eventValid = 1'b1;
        evt.pixel  = pixel[histPkg::pixelBits-1:0];
        evt.bin    = bin[histPkg::binBits-1:0];
        // saturating count
        if (modelCount[addr] < countLimit) begin
            modelCount[addr]++;
        end
    endtask

    task automatic idleCycles(input int unsigned n);
        repeat (n) begin
            @(negedge clk);
            eventValid = 1'b0;
        end
    endtask

    // queue expected peaks, strobe frameEnd, wait for the sweep to finish
    task automatic runFrame();
        histPkg::peakResult exp;
        int unsigned        bestBin;
        int unsigned        bestCount;
        int unsigned        c;
        @(negedge clk);
        eventValid = 1'b0;
        assert (!busy) else failRun($sformatf("core busy before frame end in test %s",
            testName));
        for (int p = 0; p < numPixels; p++) begin
            // lowest bin keeps a tie
            bestBin   = 0;
            bestCount = modelCount[p * numBins];
            for (int b = 1; b < numBins; b++) begin
                c = modelCount[p * numBins + b];
                if (c > bestCount) begin
                    bestBin   = b;
                    bestCount = c;
                end
            end
            exp.pixel = p[histPkg::pixelBits-1:0];
            exp.bin   = bestBin[histPkg::binBits-1:0];
            exp.count = bestCount[histPkg::countBits-1:0];
            expectQ.push_back(exp);
        end
        // next frame starts empty
        clearModel();
        frameEnd = 1'b1;
        @(negedge clk);
        frameEnd = 1'b0;
        assert (busy) else failRun($sformatf("busy did not rise after frame end in test %s",
            testName));
        while (busy) begin
            @(negedge clk);
        end
        assert (expectQ.size() == 0) else failRun($sformatf(
            "only %0d of 4 peak results arrived in test %s", 4 - expectQ.size(), testName));
    endtask

    // peak monitor, outputs are registered so negedge sees them settled
    always @(negedge clk) begin
        if (rstN && peakValid) begin
            assert (expectQ.size() > 0) else failRun($sformatf(
                "extra peak result beyond the four per frame in test %s", testName));
            expHead = expectQ.pop_front();
            assert (peak == expHead) else failRun($sformatf(
                "Error: %s expected pixel %0d bin %0d count %0d, actual pixel %0d bin %0d count %0d",
                testName, expHead.pixel, expHead.bin, expHead.count,
                peak.pixel, peak.bin, peak.count));
        end
    end

    // watchdog
    initial begin
        repeat (watchdogCycles) @(posedge clk);
        failRun($sformatf("Timeout: run did not finish within %0d cycles, stuck in test %s",
            watchdogCycles, testName));
    end

    initial begin
        int unsigned px;
        int unsigned pxB;
        int unsigned bnA;
        int unsigned bnB;
        int unsigned len;
        int unsigned mode;
        int unsigned satBin;
        rngState   = 32'h9327;
        rstN       = 1'b0;
        eventValid = 1'b0;
        frameEnd   = 1'b0;
        evt        = '0;
        testName   = "reset";
        clearModel();
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
        assert (!busy && !peakValid) else failRun("outputs not idle after reset");

        // empty sweep, also clears the ram
        testName = "emptyFrame";
        idleCycles(2);
        runFrame();

        testName = "sparseFrame";
        for (int i = 0; i < sparseEvents; i++) begin
            px  = randomBelow(numPixels);
            bnA = randomBelow(numBins);
            sendEvent(px, bnA);
            idleCycles(randomBelow(maxGap + 1));
        end
        runFrame();

        // few bins per pixel so bursts hit the same addresses often
        testName = "burstFrame";
        for (int k = 0; k < burstCount; k++) begin
            px   = randomBelow(numPixels);
            bnA  = randomBelow(4);
            pxB  = randomBelow(numPixels);
            bnB  = randomBelow(4);
            len  = 2 + randomBelow(maxBurst - 1);
            mode = randomBelow(2);
            for (int j = 0; j < len; j++) begin
                // mode 1 alternates two addresses, hits stage 3 forwarding
                if (mode == 0 || j % 2 == 0) begin
                    sendEvent(px, bnA);
                end else begin
                    sendEvent(pxB, bnB);
                end
            end
            idleCycles(randomBelow(3));
        end
        runFrame();

        testName = "saturation";
        satBin = randomBelow(numBins);
        for (int i = 0; i < saturationHits; i++) begin
            sendEvent(2, satBin);
        end
        runFrame();

        // heavy bin 3 everywhere, then a light frame that avoids it
        testName = "heavyFrame";
        for (int p = 0; p < numPixels; p++) begin
            for (int i = 0; i < heavyPerPixel; i++) begin
                sendEvent(p, 3);
            end
        end
        runFrame();

        testName = "clearedFrame";
        for (int i = 0; i < lightEvents; i++) begin
            px  = randomBelow(numPixels);
            bnA = 8 + randomBelow(numBins - 8);
            sendEvent(px, bnA);
            idleCycles(randomBelow(maxGap + 1));
        end
        runFrame();

        testName = "end";
        idleCycles(5);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
rtl/histPkg.sv
rtl/histRam.sv
rtl/histSequencer.sv
rtl/peakFinder.sv
rtl/histTop.sv
test/histTb.sv

//--- run.sh
#!/bin/sh
# build and run the histogram testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module histTb -f list.f

# the simulator exits non-zero on a fatal check, tee keeps the log either way
./obj_dir/VhistTb | tee sim.log

if grep -q "^Test OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
